/* src/udp_cmd_pkg.sv */
package udp_cmd_pkg;

    // Service ports
    localparam logic [15:0] ECHO_PORT = 16'd1234;
    localparam logic [15:0] FLASH_READ_PORT = 16'hEEE0;
    localparam logic [15:0] FLASH_REPLY_PORT = 16'hEEE1;

    // Flash read reply is a fixed size
    localparam int FLASH_READ_LEN = 128;
    localparam int UDP_HDR_LEN = 8;

    // Address bytes at the start of a read command, LSB first
    localparam int ADDR_BYTES = 3;
    localparam int FLASH_ADDR_W = 24;

    localparam logic [31:0] LOCAL_IP = {8'd192, 8'd168, 8'd2, 8'd128};

    // Reply payload buffer entries
    localparam int FIFO_DEPTH = 512;

    // UDP header as seen on both sides of the responder
    typedef struct packed {
        logic [31:0] src_ip;
        logic [31:0] dst_ip;
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [15:0] length;
    } udp_hdr_t;

    // One byte of a stream
    typedef struct packed {
        logic [7:0] data;
        logic       last;
    } beat_t;

    typedef enum logic [1:0] {
        ECHO,
        FLASH_READ,
        DROP
    } cmd_kind_t;

endpackage

/* src/cmd_rx.sv */
module cmd_rx (
    input  logic                   clk,
    input  logic                   rst,
    input  udp_cmd_pkg::udp_hdr_t  rx_hdr,
    input  logic                   rx_hdr_valid,
    output logic                   rx_hdr_ready,
    input  udp_cmd_pkg::beat_t     rx_data,
    input  logic                   rx_data_valid,
    output logic                   rx_data_ready,
    output udp_cmd_pkg::udp_hdr_t  cmd_hdr,
    output udp_cmd_pkg::cmd_kind_t cmd_kind,
    output logic [23:0]            cmd_addr,
    output logic                   cmd_valid,
    input  logic                   cmd_ready,
    output udp_cmd_pkg::beat_t     echo,
    output logic                   echo_valid,
    input  logic                   echo_ready
);

    typedef enum logic [1:0] {
        S_WAIT,
        S_IDLE,
        S_ADDR,
        S_PAYLOAD
    } state_t;

    state_t                               state;
    udp_cmd_pkg::cmd_kind_t               rx_kind;
    udp_cmd_pkg::udp_hdr_t                hdr_q;
    udp_cmd_pkg::cmd_kind_t               kind_q;
    logic [udp_cmd_pkg::FLASH_ADDR_W-1:0] addr_q;
    logic [1:0]                           addr_cnt;
    logic                                 addr_done;

    always_comb begin
        case (rx_hdr.dst_port)
            udp_cmd_pkg::ECHO_PORT:       rx_kind = udp_cmd_pkg::ECHO;
            udp_cmd_pkg::FLASH_READ_PORT: rx_kind = udp_cmd_pkg::FLASH_READ;
            default:                      rx_kind = udp_cmd_pkg::DROP;
        endcase
    end

    assign addr_done = addr_cnt == 2'(udp_cmd_pkg::ADDR_BYTES - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_WAIT;
            cmd_valid <= 1'b0;
            addr_cnt <= '0;
        end else begin
            if (cmd_valid && cmd_ready)
                cmd_valid <= 1'b0;
            case (state)
                // Hold off the next header until the builder has the command
                S_WAIT: begin
                    if (!cmd_valid)
                        state <= S_IDLE;
                end
                S_IDLE: begin
                    if (rx_hdr_valid) begin
                        addr_cnt <= '0;
                        if (rx_kind == udp_cmd_pkg::FLASH_READ) begin
                            state <= S_ADDR;
                        end else begin
                            cmd_valid <= 1'b1;
                            state <= S_PAYLOAD;
                        end
                    end
                end
                S_ADDR: begin
                    if (rx_data_valid) begin
                        addr_cnt <= addr_cnt + 2'd1;
                        if (addr_done || rx_data.last)
                            cmd_valid <= 1'b1;
                        if (rx_data.last)
                            state <= S_WAIT;
                        else if (addr_done)
                            state <= S_PAYLOAD;
                    end
                end
                default: begin
                    if (rx_data_valid && rx_data_ready && rx_data.last)
                        state <= S_WAIT;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && rx_hdr_valid) begin
            hdr_q <= rx_hdr;
            kind_q <= rx_kind;
        end
        if (state == S_ADDR && rx_data_valid)
            addr_q <= {rx_data.data, addr_q[udp_cmd_pkg::FLASH_ADDR_W-1:8]};
    end

    always_comb begin
        case (state)
            S_ADDR:    rx_data_ready = 1'b1;
            S_PAYLOAD: rx_data_ready = (kind_q == udp_cmd_pkg::ECHO) ? echo_ready : 1'b1;
            default:   rx_data_ready = 1'b0;
        endcase
    end

    assign rx_hdr_ready = state == S_IDLE;
    assign cmd_hdr = hdr_q;
    assign cmd_kind = kind_q;
    assign cmd_addr = addr_q;

    // Echo payload goes straight through
    assign echo = rx_data;
    assign echo_valid = state == S_PAYLOAD && kind_q == udp_cmd_pkg::ECHO && rx_data_valid;

endmodule

/* src/reply_builder.sv */
module reply_builder (
    input  logic                   clk,
    input  logic                   rst,
    input  udp_cmd_pkg::udp_hdr_t  cmd_hdr,
    input  udp_cmd_pkg::cmd_kind_t cmd_kind,
    input  logic [23:0]            cmd_addr,
    input  logic                   cmd_valid,
    output logic                   cmd_ready,
    input  udp_cmd_pkg::beat_t     echo,
    input  logic                   echo_valid,
    output logic                   echo_ready,
    output logic                   flash_req_valid,
    input  logic                   flash_req_ready,
    output logic [23:0]            flash_addr,
    input  logic [7:0]             flash_data,
    input  logic                   flash_data_valid,
    output logic                   flash_data_ready,
    output udp_cmd_pkg::beat_t     out_beat,
    output logic                   out_valid,
    input  logic                   out_ready,
    output udp_cmd_pkg::udp_hdr_t  out_hdr,
    output logic                   out_hdr_valid,
    input  logic                   out_hdr_ready
);

    typedef enum logic [2:0] {
        B_IDLE,
        B_ECHO,
        B_FREQ,
        B_FLASH,
        B_HDR
    } state_t;

    state_t                                        state;
    udp_cmd_pkg::udp_hdr_t                         hdr_q;
    logic [udp_cmd_pkg::FLASH_ADDR_W-1:0]          addr_q;
    logic [$clog2(udp_cmd_pkg::FLASH_READ_LEN)-1:0] flash_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= B_IDLE;
            flash_cnt <= '0;
        end else begin
            case (state)
                B_IDLE: begin
                    if (cmd_valid) begin
                        // Dropped datagrams are simply consumed here
                        if (cmd_kind == udp_cmd_pkg::ECHO)
                            state <= B_ECHO;
                        else if (cmd_kind == udp_cmd_pkg::FLASH_READ)
                            state <= B_FREQ;
                    end
                end
                B_ECHO: begin
                    if (out_valid && out_ready && out_beat.last)
                        state <= B_HDR;
                end
                B_FREQ: begin
                    if (flash_req_ready) begin
                        flash_cnt <= '0;
                        state <= B_FLASH;
                    end
                end
                B_FLASH: begin
                    if (out_valid && out_ready) begin
                        flash_cnt <= flash_cnt + 1'b1;
                        if (out_beat.last)
                            state <= B_HDR;
                    end
                end
                default: begin
                    if (out_hdr_ready)
                        state <= B_IDLE;
                end
            endcase
        end
    end

    // Reply header, swapped around the sender
    always_ff @(posedge clk) begin
        if (state == B_IDLE && cmd_valid) begin
            hdr_q.src_ip <= udp_cmd_pkg::LOCAL_IP;
            hdr_q.dst_ip <= cmd_hdr.src_ip;
            addr_q <= cmd_addr;
            if (cmd_kind == udp_cmd_pkg::FLASH_READ) begin
                hdr_q.src_port <= udp_cmd_pkg::FLASH_READ_PORT;
                hdr_q.dst_port <= udp_cmd_pkg::FLASH_REPLY_PORT;
                hdr_q.length <= 16'(udp_cmd_pkg::FLASH_READ_LEN + udp_cmd_pkg::UDP_HDR_LEN);
            end else begin
                hdr_q.src_port <= udp_cmd_pkg::ECHO_PORT;
                hdr_q.dst_port <= cmd_hdr.src_port;
                hdr_q.length <= cmd_hdr.length;
            end
        end
    end

    always_comb begin
        out_beat = echo;
        out_valid = 1'b0;
        if (state == B_ECHO) begin
            out_valid = echo_valid;
        end else if (state == B_FLASH) begin
            out_beat.data = flash_data;
            out_beat.last = flash_cnt == ($clog2(udp_cmd_pkg::FLASH_READ_LEN))'(
                udp_cmd_pkg::FLASH_READ_LEN - 1);
            out_valid = flash_data_valid;
        end
    end

    assign cmd_ready = state == B_IDLE;
    assign echo_ready = state == B_ECHO && out_ready;
    assign flash_req_valid = state == B_FREQ;
    assign flash_addr = addr_q;
    assign flash_data_ready = state == B_FLASH && out_ready;
    assign out_hdr = hdr_q;
    assign out_hdr_valid = state == B_HDR;

endmodule

/* src/reply_tx.sv */
module reply_tx (
    input  logic                  clk,
    input  logic                  rst,
    input  udp_cmd_pkg::beat_t    out_beat,
    input  logic                  out_valid,
    output logic                  out_ready,
    input  udp_cmd_pkg::udp_hdr_t out_hdr,
    input  logic                  out_hdr_valid,
    output logic                  out_hdr_ready,
    output udp_cmd_pkg::udp_hdr_t tx_hdr,
    output logic                  tx_hdr_valid,
    input  logic                  tx_hdr_ready,
    output udp_cmd_pkg::beat_t    tx_data,
    output logic                  tx_data_valid,
    input  logic                  tx_data_ready
);

    udp_cmd_pkg::beat_t                       mem [udp_cmd_pkg::FIFO_DEPTH];
    logic [$clog2(udp_cmd_pkg::FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(udp_cmd_pkg::FIFO_DEPTH)-1:0] rd_ptr;
    logic [$clog2(udp_cmd_pkg::FIFO_DEPTH):0]   count;

    udp_cmd_pkg::udp_hdr_t hq [2];
    logic                  hq_wr;
    logic                  hq_rd;
    logic [1:0]            hq_count;

    // High between a header transfer and the last beat of its reply
    logic sending;
    logic wr;
    logic rd;
    logic h_wr;
    logic h_rd;

    assign wr = out_valid && out_ready;
    assign rd = tx_data_valid && tx_data_ready;
    assign h_wr = out_hdr_valid && out_hdr_ready;
    assign h_rd = tx_hdr_valid && tx_hdr_ready;

    always_ff @(posedge clk) begin
        if (wr)
            mem[wr_ptr] <= out_beat;
        if (h_wr)
            hq[hq_wr] <= out_hdr;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            hq_wr <= 1'b0;
            hq_rd <= 1'b0;
            hq_count <= '0;
            sending <= 1'b0;
        end else begin
            if (wr)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd)
                rd_ptr <= rd_ptr + 1'b1;
            case ({wr, rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
            if (h_wr)
                hq_wr <= ~hq_wr;
            if (h_rd)
                hq_rd <= ~hq_rd;
            case ({h_wr, h_rd})
                2'b10:   hq_count <= hq_count + 2'd1;
                2'b01:   hq_count <= hq_count - 2'd1;
                default: ;
            endcase
            if (h_rd)
                sending <= 1'b1;
            else if (rd && tx_data.last)
                sending <= 1'b0;
        end
    end

    assign out_ready = count != udp_cmd_pkg::FIFO_DEPTH;
    assign out_hdr_ready = hq_count != 2'd2;
    assign tx_hdr = hq[hq_rd];
    assign tx_hdr_valid = hq_count != 2'd0 && !sending;
    assign tx_data = mem[rd_ptr];
    assign tx_data_valid = sending && count != '0;

endmodule

/* src/udp_cmd_top.sv */
module udp_cmd_top (
    input  logic                  clk,
    input  logic                  rst,
    input  udp_cmd_pkg::udp_hdr_t rx_hdr,
    input  logic                  rx_hdr_valid,
    output logic                  rx_hdr_ready,
    input  udp_cmd_pkg::beat_t    rx_data,
    input  logic                  rx_data_valid,
    output logic                  rx_data_ready,
    output logic                  flash_req_valid,
    input  logic                  flash_req_ready,
    output logic [23:0]           flash_addr,
    input  logic [7:0]            flash_data,
    input  logic                  flash_data_valid,
    output logic                  flash_data_ready,
    output udp_cmd_pkg::udp_hdr_t tx_hdr,
    output logic                  tx_hdr_valid,
    input  logic                  tx_hdr_ready,
    output udp_cmd_pkg::beat_t    tx_data,
    output logic                  tx_data_valid,
    input  logic                  tx_data_ready
);

    udp_cmd_pkg::udp_hdr_t  cmd_hdr;
    udp_cmd_pkg::cmd_kind_t cmd_kind;
    logic [23:0]            cmd_addr;
    logic                   cmd_valid;
    logic                   cmd_ready;
    udp_cmd_pkg::beat_t     echo;
    logic                   echo_valid;
    logic                   echo_ready;
    udp_cmd_pkg::beat_t     out_beat;
    logic                   out_valid;
    logic                   out_ready;
    udp_cmd_pkg::udp_hdr_t  out_hdr;
    logic                   out_hdr_valid;
    logic                   out_hdr_ready;

    cmd_rx u_cmd_rx (
        .clk(clk), .rst(rst),
        .rx_hdr(rx_hdr), .rx_hdr_valid(rx_hdr_valid), .rx_hdr_ready(rx_hdr_ready),
        .rx_data(rx_data), .rx_data_valid(rx_data_valid), .rx_data_ready(rx_data_ready),
        .cmd_hdr(cmd_hdr), .cmd_kind(cmd_kind), .cmd_addr(cmd_addr),
        .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
        .echo(echo), .echo_valid(echo_valid), .echo_ready(echo_ready)
    );

    reply_builder u_reply_builder (
        .clk(clk), .rst(rst),
        .cmd_hdr(cmd_hdr), .cmd_kind(cmd_kind), .cmd_addr(cmd_addr),
        .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
        .echo(echo), .echo_valid(echo_valid), .echo_ready(echo_ready),
        .flash_req_valid(flash_req_valid), .flash_req_ready(flash_req_ready),
        .flash_addr(flash_addr),
        .flash_data(flash_data), .flash_data_valid(flash_data_valid),
        .flash_data_ready(flash_data_ready),
        .out_beat(out_beat), .out_valid(out_valid), .out_ready(out_ready),
        .out_hdr(out_hdr), .out_hdr_valid(out_hdr_valid), .out_hdr_ready(out_hdr_ready)
    );

    reply_tx u_reply_tx (
        .clk(clk), .rst(rst),
        .out_beat(out_beat), .out_valid(out_valid), .out_ready(out_ready),
        .out_hdr(out_hdr), .out_hdr_valid(out_hdr_valid), .out_hdr_ready(out_hdr_ready),
        .tx_hdr(tx_hdr), .tx_hdr_valid(tx_hdr_valid), .tx_hdr_ready(tx_hdr_ready),
        .tx_data(tx_data), .tx_data_valid(tx_data_valid), .tx_data_ready(tx_data_ready)
    );

endmodule

/* tb/tb_clock.sv */
module tb_clock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Reset held for 10 cycles, released just after an edge
    initial begin
        rst = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

/* tb/tb_flash_model.sv */
module tb_flash_model (
    input  logic        clk,
    input  logic        rst,
    input  logic        pace,
    input  logic        req_valid,
    output logic        req_ready,
    input  logic [23:0] addr,
    output logic [7:0]  data,
    output logic        data_valid,
    input  logic        data_ready
);

    logic [23:0] cur;
    logic [23:0] req_addr;
    int          left;
    logic        in_reset;
    logic        req_fire;
    logic        data_fire;

    initial begin
        req_ready = 1'b0;
        data_valid = 1'b0;
        data = '0;
        cur = '0;
        left = 0;
    end

    // Handshakes sampled mid-cycle, outputs updated just after the edge
    always begin
        @(negedge clk);
        in_reset = rst;
        req_fire = req_valid && req_ready;
        data_fire = data_valid && data_ready;
        req_addr = addr;
        @(posedge clk);
        #1;
        if (in_reset) begin
            req_ready = 1'b0;
            data_valid = 1'b0;
            left = 0;
        end else begin
            if (req_fire) begin
                cur = req_addr;
                left = udp_cmd_pkg::FLASH_READ_LEN;
            end
            if (data_fire) begin
                cur = cur + 24'd1;
                left = left - 1;
                data_valid = 1'b0;
            end
            req_ready = left == 0;
            // Byte content is low address byte XOR middle address byte
            data = cur[7:0] ^ cur[15:8];
            if (left != 0 && !data_valid && pace)
                data_valid = 1'b1;
        end
    end

endmodule

/* tb/udp_cmd_checker.sv */
module udp_cmd_checker (
    input logic                  clk,
    input logic                  rst,
    input udp_cmd_pkg::udp_hdr_t tx_hdr,
    input logic                  tx_hdr_valid,
    input logic                  tx_hdr_ready,
    input udp_cmd_pkg::beat_t    tx_data,
    input logic                  tx_data_valid,
    input logic                  tx_data_ready,
    input logic                  flash_req_valid
);

    int   fail_count = 0;
    // Set between a header transfer and the last beat of that reply
    logic hdr_open;

    always_ff @(posedge clk) begin
        if (rst)
            hdr_open <= 1'b0;
        else if (tx_hdr_valid && tx_hdr_ready)
            hdr_open <= 1'b1;
        else if (tx_data_valid && tx_data_ready && tx_data.last)
            hdr_open <= 1'b0;
    end

    hdr_hold: assert property (@(posedge clk) disable iff (rst)
        tx_hdr_valid && !tx_hdr_ready |=> tx_hdr_valid && $stable(tx_hdr))
        else begin
            $error("tx_hdr dropped or changed before its transfer");
            fail_count++;
        end

    data_hold: assert property (@(posedge clk) disable iff (rst)
        tx_data_valid && !tx_data_ready |=> tx_data_valid && $stable(tx_data))
        else begin
            $error("tx_data dropped or changed before its transfer");
            fail_count++;
        end

    data_after_hdr: assert property (@(posedge clk) disable iff (rst)
        tx_data_valid |-> hdr_open)
        else begin
            $error("tx_data offered before the reply header went out");
            fail_count++;
        end

    req_low_after_rst: assert property (@(posedge clk) rst |=> !flash_req_valid)
        else begin
            $error("flash_req_valid high right after reset");
            fail_count++;
        end

endmodule

bind udp_cmd_top udp_cmd_checker u_checker (
    .clk(clk), .rst(rst),
    .tx_hdr(tx_hdr), .tx_hdr_valid(tx_hdr_valid), .tx_hdr_ready(tx_hdr_ready),
    .tx_data(tx_data), .tx_data_valid(tx_data_valid), .tx_data_ready(tx_data_ready),
    .flash_req_valid(flash_req_valid)
);

/* tb/tb_top.sv */
module tb_top;

    localparam int NUM_DGRAMS = 60;
    localparam int TIMEOUT_CYCLES = NUM_DGRAMS * 400;

    logic                  clk;
    logic                  rst;
    udp_cmd_pkg::udp_hdr_t rx_hdr;
    logic                  rx_hdr_valid;
    logic                  rx_hdr_ready;
    udp_cmd_pkg::beat_t    rx_data;
    logic                  rx_data_valid;
    logic                  rx_data_ready;
    logic                  flash_req_valid;
    logic                  flash_req_ready;
    logic [23:0]           flash_addr;
    logic [7:0]            flash_data;
    logic                  flash_data_valid;
    logic                  flash_data_ready;
    udp_cmd_pkg::udp_hdr_t tx_hdr;
    logic                  tx_hdr_valid;
    logic                  tx_hdr_ready;
    udp_cmd_pkg::beat_t    tx_data;
    logic                  tx_data_valid;
    logic                  tx_data_ready;
    logic                  flash_pace;

    udp_cmd_pkg::udp_hdr_t stim_hdrs[$];
    int                    stim_lens[$];
    udp_cmd_pkg::beat_t    stim_bytes[$];
    udp_cmd_pkg::udp_hdr_t exp_hdrs[$];
    udp_cmd_pkg::beat_t    exp_bytes[$];
    logic [23:0]           exp_addrs[$];
    int                    n_replies = 0;
    int                    replies_done = 0;
    int                    cycle_count = 0;
    // 16-bit register, so the seed keeps its low 16 bits
    logic [15:0]           lfsr_state = 16'(94928);

    tb_clock u_clock (.clk(clk), .rst(rst));

    udp_cmd_top DUT (.*);

    tb_flash_model u_flash (
        .clk(clk), .rst(rst), .pace(flash_pace),
        .req_valid(flash_req_valid), .req_ready(flash_req_ready), .addr(flash_addr),
        .data(flash_data), .data_valid(flash_data_valid), .data_ready(flash_data_ready)
    );

    // Fibonacci LFSR, taps 16 14 13 11, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_eq(input logic [111:0] got, input logic [111:0] exp,
                            input string what);
        if (got !== exp)
            fail_run($sformatf("ERROR at time %0t: %s is %h, expected %h",
                               $time, what, got, exp));
    endtask

    // Classes 0 and 1 echo, 2 reads flash, 3 goes to an unused port
    task automatic build_tests();
        udp_cmd_pkg::udp_hdr_t h;
        udp_cmd_pkg::udp_hdr_t r;
        udp_cmd_pkg::beat_t    b;
        logic [1:0]            cls;
        logic [23:0]           addr;
        logic [23:0]           a;
        int                    len;
        for (int i = 0; i < NUM_DGRAMS; i++) begin
            cls = rand_bits(2);
            h.src_ip = rand_bits(32);
            h.dst_ip = udp_cmd_pkg::LOCAL_IP;
            h.src_port = rand_bits(16);
            len = rand_bits(6) % 40 + 1;
            addr = '0;
            if (cls == 2'd2) begin
                h.dst_port = udp_cmd_pkg::FLASH_READ_PORT;
                addr = rand_bits(24);
                if (len < 3)
                    len = 3;
            end else if (cls == 2'd3) begin
                h.dst_port = rand_bits(16);
                if (h.dst_port == udp_cmd_pkg::ECHO_PORT ||
                    h.dst_port == udp_cmd_pkg::FLASH_READ_PORT)
                    h.dst_port = 16'd7;
            end else begin
                h.dst_port = udp_cmd_pkg::ECHO_PORT;
            end
            h.length = 16'(len + 8);
            stim_hdrs.push_back(h);
            stim_lens.push_back(len);
            for (int k = 0; k < len; k++) begin
                // Address goes out least significant byte first
                if (cls == 2'd2 && k < 3)
                    b.data = addr[8*k +: 8];
                else
                    b.data = 8'(rand_bits(8));
                b.last = k == len - 1;
                stim_bytes.push_back(b);
                if (cls < 2'd2)
                    exp_bytes.push_back(b);
            end
            r.src_ip = udp_cmd_pkg::LOCAL_IP;
            r.dst_ip = h.src_ip;
            if (cls < 2'd2) begin
                r.src_port = 16'd1234;
                r.dst_port = h.src_port;
                r.length = h.length;
                exp_hdrs.push_back(r);
                n_replies++;
            end else if (cls == 2'd2) begin
                r.src_port = 16'hEEE0;
                r.dst_port = 16'hEEE1;
                r.length = 16'd136;
                exp_hdrs.push_back(r);
                exp_addrs.push_back(addr);
                n_replies++;
                for (int k = 0; k < 128; k++) begin
                    a = addr + 24'(k);
                    b.data = a[7:0] ^ a[15:8];
                    b.last = k == 127;
                    exp_bytes.push_back(b);
                end
            end
        end
    endtask

    task automatic send_hdr(input udp_cmd_pkg::udp_hdr_t h);
        logic fire;
        rx_hdr = h;
        rx_hdr_valid = 1'b1;
        fire = 1'b0;
        while (!fire) begin
            @(negedge clk);
            fire = rx_hdr_ready;
            @(posedge clk);
            #1;
        end
        rx_hdr_valid = 1'b0;
    endtask

    task automatic send_beat(input udp_cmd_pkg::beat_t b);
        logic fire;
        rx_data = b;
        rx_data_valid = 1'b1;
        fire = 1'b0;
        while (!fire) begin
            @(negedge clk);
            fire = rx_data_ready;
            @(posedge clk);
            #1;
        end
        rx_data_valid = 1'b0;
    endtask

    initial begin
        rx_hdr = '0;
        rx_hdr_valid = 1'b0;
        rx_data = '0;
        rx_data_valid = 1'b0;
        tx_hdr_ready = 1'b0;
        tx_data_ready = 1'b0;
        flash_pace = 1'b0;
        build_tests();
        @(negedge rst);
        for (int i = 0; i < NUM_DGRAMS; i++) begin
            send_hdr(stim_hdrs[i]);
            for (int k = 0; k < stim_lens[i]; k++)
                send_beat(stim_bytes.pop_front());
        end
        wait (replies_done == n_replies);
        // Quiet time so a stray reply would still be caught
        repeat (200) @(posedge clk);
        if (DUT.u_checker.fail_count == 0 && exp_hdrs.size() == 0 &&
            exp_bytes.size() == 0 && exp_addrs.size() == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            fail_run("Run ended with expected replies missing or a failed assertion");
        end
    end

    // Output monitor and random ready patterns
    always begin
        @(negedge clk);
        if (DUT.u_checker.fail_count != 0)
            fail_run("A protocol assertion on the DUT outputs failed");
        if (flash_req_valid && flash_req_ready) begin
            if (exp_addrs.size() == 0)
                fail_run("A flash read was requested with no read expected");
            check_eq(flash_addr, exp_addrs.pop_front(), "flash read address");
        end
        if (tx_hdr_valid && tx_hdr_ready) begin
            if (exp_hdrs.size() == 0)
                fail_run("A reply header came out with no reply expected");
            check_eq(tx_hdr, exp_hdrs.pop_front(), "reply header");
        end
        if (tx_data_valid && tx_data_ready) begin
            if (exp_bytes.size() == 0)
                fail_run("A reply byte came out with no byte expected");
            check_eq(tx_data, exp_bytes.pop_front(), "reply beat {data,last}");
            if (tx_data.last)
                replies_done++;
        end
        @(posedge clk);
        #1;
        tx_hdr_ready = rand_bits(1);
        tx_data_ready = rand_bits(2) != 0;
        flash_pace = rand_bits(1);
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
            fail_run($sformatf("Timeout: replies not finished after %0d cycles",
                               TIMEOUT_CYCLES));
    end

endmodule

/* src.f */
src/udp_cmd_pkg.sv
src/cmd_rx.sv
src/reply_builder.sv
src/reply_tx.sv
src/udp_cmd_top.sv
tb/tb_clock.sv
tb/tb_flash_model.sv
tb/udp_cmd_checker.sv
tb/tb_top.sv
